//--- tb.f
+incdir+verilog
verilog/pack_pkg.sv
verilog/pack_bfifo_if.sv
verilog/pack_fifo.sv
verilog/pack_bfifo.sv
verilog/pack_bit_count.sv
verilog/pack_ctrl.sv
verilog/pack_top.sv
testbench/pack_assert.sv
testbench/tb_pack.sv

//--- Bender.yml
package:
  name: pack

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pack_pkg.sv
      - verilog/pack_bfifo_if.sv
      - verilog/pack_fifo.sv
      - verilog/pack_bfifo.sv
      - verilog/pack_bit_count.sv
      - verilog/pack_ctrl.sv
      - verilog/pack_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/pack_assert.sv
      - testbench/tb_pack.sv

//--- testbench/tb_pack.sv
`include "pack_macros.svh"

module tb_pack;

   localparam logic [31:0] SEED       = 32'h3600_ea2f;
   localparam int          WAIT_LIMIT = 2000;
   // longer than any low stretch of in_ready_o while the controller still fetches
   localparam int          STALL_RUN  = 8;

   logic                     clk_i = 1'b0;
   logic                     rst_i;
   logic                     in_valid_i;
   logic                     in_ready_o;
   logic [`PACK_FIELD_W-1:0] in_data_i;
   logic [`PACK_LEN_W-1:0]   in_len_i;
   logic                     in_last_i;
   logic                     out_valid_o;
   logic                     out_ready_i;
   logic [`PACK_WORD_W-1:0]  out_data_o;

   logic [31:0] lfsr_q = SEED;
   // expected bit stream with the oldest bit at the front
   logic        model_bits[$];
   int          model_fill = 0;
   int          mismatches = 0;
   int          other_errors = 0;
   // 0 random stalls, 1 always ready, 2 held off
   int          ready_mode = 1;
   logic        in_fire = 1'b0;
   int          in_low_run = 0;
   logic        saw_in_stall = 1'b0;
   logic        timed_out = 1'b0;

   pack_top i_dut (.*);

   always #2 clk_i = ~clk_i;

   // galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic int take_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = (v << 1) | lfsr_q[0];
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
      case (ready_mode)
         0: out_ready_i = (take_bits(2) != 0);
         1: out_ready_i = 1'b1;
         default: out_ready_i = 1'b0;
      endcase
   endtask

   // offer one field and hold it until the input queue takes it
   task automatic send_field(input logic [7:0] data, input int len, input logic last);
      int waited;
      waited = 0;
      if (timed_out) return;
      in_valid_i = 1'b1;
      in_data_i  = data;
      in_len_i   = `PACK_LEN_W'(len);
      in_last_i  = last;
      do begin
         next_cycle();
         waited++;
      end while (!in_fire && waited < WAIT_LIMIT);
      if (!in_fire) begin
         timed_out = 1'b1;
         other_errors++;
         $display("error at %0t: input queue never took a field", $time);
      end
      in_valid_i = 1'b0;
   endtask

   task automatic send_random(input logic force_last);
      logic [7:0] data;
      int         len;
      logic       last;
      data = take_bits(8);
      len  = take_bits(3) + 1;
      last = (take_bits(3) == 0) || force_last;
      send_field(data, len, last);
   endtask

   // wait until every expected bit has come out, then watch for stray words
   task automatic drain();
      int waited;
      waited = 0;
      ready_mode = 1;
      while (model_bits.size() != 0 && waited < WAIT_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (model_bits.size() != 0) begin
         timed_out = 1'b1;
         other_errors++;
         $display("error at %0t: %0d bits never came out", $time, model_bits.size());
      end
      repeat (20) next_cycle();
   endtask

   // the monitor samples at the falling edge where all handshakes are settled
   always @(negedge clk_i) begin
      logic [31:0] expected;
      in_fire = in_valid_i && in_ready_o && !rst_i;
      if (!rst_i && !in_ready_o) begin
         in_low_run++;
      end else begin
         in_low_run = 0;
      end
      if (in_low_run >= STALL_RUN) begin
         saw_in_stall = 1'b1;
      end
      if (in_fire) begin
         for (int i = in_len_i - 1; i >= 0; i--) begin
            model_bits.push_back(in_data_i[i]);
         end
         model_fill = (model_fill + in_len_i) % 32;
         if (in_last_i && model_fill != 0) begin
            repeat (32 - model_fill) model_bits.push_back(1'b0);
            model_fill = 0;
         end
      end
      if (!rst_i && out_valid_o && out_ready_i) begin
         if (model_bits.size() < 32) begin
            other_errors++;
            $display("error at %0t: word on out_data_o with no bits expected", $time);
         end else begin
            for (int i = 31; i >= 0; i--) begin
               expected[i] = model_bits.pop_front();
            end
            if (out_data_o !== expected) begin
               mismatches++;
               $display("mismatch at %0t: out_data_o expected %h actual %h",
                        $time, expected, out_data_o);
            end
         end
      end
   end

   initial begin
      rst_i       = 1'b1;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      in_len_i    = 4'd1;
      in_last_i   = 1'b0;
      out_ready_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      repeat (8) next_cycle();

      // random fields with input gaps and output stalls
      ready_mode = 0;
      for (int n = 0; n < 300; n++) begin
         if (take_bits(2) == 0) begin
            next_cycle();
         end
         send_random(1'b0);
      end
      send_random(1'b1);
      drain();

      // four full fields end on the boundary and need no pad word
      repeat (3) send_field(8'ha5, 8, 1'b0);
      send_field(8'h3c, 8, 1'b1);
      drain();
      // a short last field needs 29 pad bits
      send_field(8'h05, 3, 1'b1);
      // fields straddling a word boundary
      repeat (7) send_field(8'h1b, 5, 1'b0);
      send_field(8'hff, 1, 1'b1);
      drain();

      // output held off for 100 cycles
      saw_in_stall = 1'b0;
      ready_mode   = 2;
      for (int cyc = 0; cyc < 100; cyc++) begin
         if (!in_valid_i) begin
            in_valid_i = 1'b1;
            in_data_i  = take_bits(8);
            in_len_i   = `PACK_LEN_W'(take_bits(3) + 1);
            in_last_i  = (take_bits(3) == 0);
         end
         next_cycle();
         if (in_fire) begin
            in_valid_i = 1'b0;
         end
      end
      if (!saw_in_stall) begin
         other_errors++;
         $display("error at %0t: in_ready_o never stayed low while the output was held off",
                  $time);
      end
      ready_mode = 1;
      if (in_valid_i) begin
         send_field(in_data_i, in_len_i, in_last_i);
      end
      send_random(1'b1);
      drain();

      $display("errors: %0d mismatches, %0d other, %0d assertion failures",
               mismatches, other_errors, i_dut.i_assert.fail_count);
      if (mismatches + other_errors + i_dut.i_assert.fail_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- testbench/pack_assert.sv
`include "pack_macros.svh"

module pack_assert (
   input logic                     clk_i,
   input logic                     rst_i,
   input logic                     in_ready_i,
   input logic                     out_valid_i,
   input logic                     out_ready_i,
   input logic [`PACK_WORD_W-1:0]  out_data_i,
   input logic                     push_i,
   input logic                     pop_i,
   input logic [`PACK_LEVEL_W-1:0] pop_level_i
);

   int unsigned fail_count = 0;

   // quiet outputs and idle bit fifo for the first cycles out of reset
   a_idle_after_reset: assert property (@(posedge clk_i)
      $fell(rst_i) |-> (!out_valid_i && in_ready_i && !push_i && !pop_i) [*6])
   else begin
      fail_count++;
      $error("outputs not idle after reset");
   end

   // a stalled word keeps its data until taken
   a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
   else begin
      fail_count++;
      $error("output word changed or dropped while stalled");
   end

   a_push_pop_excl: assert property (@(posedge clk_i) disable iff (rst_i)
      !(push_i && pop_i))
   else begin
      fail_count++;
      $error("bit fifo push and pop in the same cycle");
   end

   a_level_max: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_level_i <= `PACK_LEVEL_W'(`PACK_BFIFO_W))
   else begin
      fail_count++;
      $error("bit fifo level above capacity");
   end

endmodule

bind pack_top pack_assert i_assert (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .in_ready_i (in_ready_o),
   .out_valid_i(out_valid_o),
   .out_ready_i(out_ready_i),
   .out_data_i (out_data_o),
   .push_i     (bf.push),
   .pop_i      (bf.pop),
   .pop_level_i(bf.pop_level)
);

//--- verilog/pack_top.sv
`include "pack_macros.svh"

module pack_top
   import pack_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_i,

   // field input
   input  logic                    in_valid_i,
   output logic                    in_ready_o,
   input  logic [`PACK_FIELD_W-1:0] in_data_i,
   input  logic [`PACK_LEN_W-1:0]  in_len_i,
   input  logic                    in_last_i,

   // packed word output
   output logic                    out_valid_o,
   input  logic                    out_ready_i,
   output logic [`PACK_WORD_W-1:0] out_data_o
);

   pack_field_t              in_field;
   pack_field_t              field;
   logic                     field_valid;
   logic                     field_ready;
   logic                     word_valid;
   logic                     word_ready;
   logic [`PACK_LEVEL_W-1:0] pad_len;

   pack_bfifo_if bf ();

   assign in_field = '{data: in_data_i, len: in_len_i, last: in_last_i};

   // fields waiting for the controller
   pack_fifo #(
      .payload_t(pack_field_t),
      .DEPTH    (`PACK_QUEUE_DEPTH)
   ) i_in_queue (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wr_valid_i(in_valid_i),
      .wr_ready_o(in_ready_o),
      .wr_data_i (in_field),
      .rd_valid_o(field_valid),
      .rd_ready_i(field_ready),
      .rd_data_o (field)
   );

   pack_ctrl i_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .field_valid_i(field_valid),
      .field_ready_o(field_ready),
      .field_i      (field),
      .word_ready_i (word_ready),
      .word_valid_o (word_valid),
      .pad_len_i    (pad_len),
      .bf           (bf.ctrl)
   );

   pack_bit_count i_bit_count (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .bf       (bf.ctrl),
      .pad_len_o(pad_len)
   );

   pack_bfifo i_bfifo (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .bf   (bf.fifo)
   );

   // popped words go straight into the output queue
   pack_fifo #(
      .payload_t(pack_word_t),
      .DEPTH    (`PACK_QUEUE_DEPTH)
   ) i_out_queue (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wr_valid_i(word_valid),
      .wr_ready_o(word_ready),
      .wr_data_i (bf.pop_data),
      .rd_valid_o(out_valid_o),
      .rd_ready_i(out_ready_i),
      .rd_data_o (out_data_o)
   );

endmodule

//--- verilog/pack_ctrl.sv
`include "pack_macros.svh"

module pack_ctrl
   import pack_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_i,

   // field side, from the input queue
   input  logic                     field_valid_i,
   output logic                     field_ready_o,
   input  pack_field_t              field_i,

   // word side, into the output queue
   input  logic                     word_ready_i,
   output logic                     word_valid_o,

   input  logic [`PACK_LEVEL_W-1:0] pad_len_i,
   pack_bfifo_if.ctrl               bf
);

   localparam logic [`PACK_LEVEL_W-1:0] WORD_LEVEL = `PACK_LEVEL_W'(`PACK_WORD_W);

   pack_state_t              state_q;
   pack_state_t              state_d;
   pack_field_t              held_q;
   logic [`PACK_FIELD_W-1:0] held_aligned;
   logic [`PACK_LEVEL_W-1:0] held_len;
   logic                     push_field;
   logic                     push_pad;
   logic                     pop_go;
   logic                     fetch;

   // low len bits moved to the top of the field
   assign held_aligned = held_q.data << (`PACK_FIELD_W - held_q.len);
   assign held_len     = {{(`PACK_LEVEL_W - `PACK_LEN_W){1'b0}}, held_q.len};

   // priority is field push, pad push, pop, then fetch
   assign push_field = (state_q == HELD) && (bf.push_room >= held_len);
   assign push_pad   = (state_q == PAD) && (pad_len_i != '0) && (bf.push_room >= pad_len_i);
   assign pop_go     = !push_field && !push_pad && (bf.pop_level >= WORD_LEVEL) && word_ready_i;

   assign field_ready_o = (state_q == EMPTY) && !pop_go;
   assign fetch         = field_valid_i && field_ready_o;

   assign bf.push      = push_field | push_pad;
   assign bf.push_len  = push_pad ? pad_len_i : held_len;
   assign bf.push_data = push_pad ? '0 : {held_aligned, {(`PACK_WORD_W - `PACK_FIELD_W){1'b0}}};
   assign bf.pop       = pop_go;
   assign word_valid_o = pop_go;

   always_comb begin
      state_d = state_q;
      case (state_q)
         EMPTY: if (fetch) state_d = HELD;
         HELD:  if (push_field) state_d = held_q.last ? PAD : EMPTY;
         // a zero pad length means the field ended on a boundary
         PAD:   if (push_pad || (pad_len_i == '0)) state_d = EMPTY;
         default: state_d = EMPTY;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= EMPTY;
      end else begin
         state_q <= state_d;
      end
   end

   // holding register for the fetched field
   always_ff @(posedge clk_i) begin
      if (fetch) begin
         held_q <= field_i;
      end
   end

endmodule

//--- verilog/pack_bit_count.sv
`include "pack_macros.svh"

module pack_bit_count (
   input  logic                     clk_i,
   input  logic                     rst_i,
   // only push and push_len are looked at
   pack_bfifo_if.ctrl               bf,
   output logic [`PACK_LEVEL_W-1:0] pad_len_o
);

   localparam int unsigned CNT_W = $clog2(`PACK_WORD_W);

   localparam logic [`PACK_LEVEL_W-1:0] WORD_LEVEL = `PACK_LEVEL_W'(`PACK_WORD_W);

   // bit position inside the current word
   logic [CNT_W-1:0]         count_q;
   logic [`PACK_LEVEL_W-1:0] count_ext;

   // wraps naturally at the word width
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (bf.push) begin
         count_q <= count_q + bf.push_len[CNT_W-1:0];
      end
   end

   assign count_ext = {{(`PACK_LEVEL_W - CNT_W){1'b0}}, count_q};

   // no pad on a word boundary
   assign pad_len_o = (count_q == '0) ? '0 : WORD_LEVEL - count_ext;

endmodule

//--- verilog/pack_bfifo.sv
`include "pack_macros.svh"

module pack_bfifo (
   input logic        clk_i,
   input logic        rst_i,
   pack_bfifo_if.fifo bf
);

   localparam int unsigned REG_W  = `PACK_BFIFO_W;
   localparam int unsigned WORD_W = `PACK_WORD_W;

   // capacity and word size as level values
   localparam logic [`PACK_LEVEL_W-1:0] REG_LEVEL  = `PACK_LEVEL_W'(`PACK_BFIFO_W);
   localparam logic [`PACK_LEVEL_W-1:0] WORD_LEVEL = `PACK_LEVEL_W'(`PACK_WORD_W);

   // bits are stored from the top down, oldest bit at REG_W-1
   logic [REG_W-1:0]         data_q;
   logic [REG_W-1:0]         data_d;
   logic [`PACK_LEVEL_W-1:0] level_q;
   logic [`PACK_LEVEL_W-1:0] level_d;

   // top push_len bits of the incoming data
   logic [REG_W-1:0]         push_mask;
   logic [REG_W-1:0]         push_bits;
   // top level bits of the stored data
   logic [REG_W-1:0]         keep_mask;

   assign push_mask = ~({REG_W{1'b1}} >> bf.push_len);
   assign push_bits = {bf.push_data, {(REG_W - WORD_W){1'b0}}} & push_mask;
   assign keep_mask = ~({REG_W{1'b1}} >> level_q);

   // push and pop never come together, push wins if they did
   always_comb begin
      data_d  = data_q;
      level_d = level_q;
      if (bf.push) begin
         // new bits go right below the ones already held
         data_d  = (data_q & keep_mask) | (push_bits >> level_q);
         level_d = level_q + bf.push_len;
      end else if (bf.pop) begin
         data_d  = data_q << WORD_W;
         level_d = level_q - WORD_LEVEL;
      end
   end

   // bit storage
   always_ff @(posedge clk_i) begin
      data_q <= data_d;
   end

   // fill level in bits
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         level_q <= '0;
      end else begin
         level_q <= level_d;
      end
   end

   assign bf.push_room = REG_LEVEL - level_q;
   assign bf.pop_level = level_q;
   // oldest word sits at the top
   assign bf.pop_data  = data_q[REG_W-1 -: WORD_W];

endmodule

//--- verilog/pack_fifo.sv
module pack_fifo #(
   parameter type         payload_t = logic [7:0],
   parameter int unsigned DEPTH     = 4
) (
   input  logic     clk_i,
   input  logic     rst_i,

   // write side
   input  logic     wr_valid_i,
   output logic     wr_ready_o,
   input  payload_t wr_data_i,

   // read side
   output logic     rd_valid_o,
   input  logic     rd_ready_i,
   output payload_t rd_data_o
);

   // a single entry still needs one pointer bit
   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_write;
   logic             do_read;

   // ready and valid come from the fill level only
   assign wr_ready_o = (count_q != FULL_CNT);
   assign rd_valid_o = (count_q != '0);
   assign rd_data_o  = mem[rd_ptr_q];

   assign do_write = wr_valid_i & wr_ready_o;
   assign do_read  = rd_valid_o & rd_ready_i;

   // storage
   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   // pointers wrap at DEPTH
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (do_write) begin
            wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_read) begin
            rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
         end
      end
   end

   // fill level, unchanged on a simultaneous read and write
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (do_write && !do_read) begin
         count_q <= count_q + 1'b1;
      end else if (do_read && !do_write) begin
         count_q <= count_q - 1'b1;
      end
   end

endmodule

//--- verilog/pack_bfifo_if.sv
`include "pack_macros.svh"

interface pack_bfifo_if;

   // push side, data is left aligned, only the top push_len bits count
   logic                     push;
   logic [`PACK_LEVEL_W-1:0] push_len;
   logic [`PACK_WORD_W-1:0]  push_data;
   // free bits left in the fifo
   logic [`PACK_LEVEL_W-1:0] push_room;

   // pop side, always removes a full word
   logic                     pop;
   logic [`PACK_WORD_W-1:0]  pop_data;
   logic [`PACK_LEVEL_W-1:0] pop_level;

   modport ctrl (
      output push,
      output push_len,
      output push_data,
      output pop,
      input  push_room,
      input  pop_data,
      input  pop_level
   );

   modport fifo (
      input  push,
      input  push_len,
      input  push_data,
      input  pop,
      output push_room,
      output pop_data,
      output pop_level
   );

endinterface

//--- verilog/pack_pkg.sv
`include "pack_macros.svh"

package pack_pkg;

   // one variable-length field as it sits in the input queue
   typedef struct packed {
      // payload, only the low len bits are used
      logic [`PACK_FIELD_W-1:0] data;
      // number of valid bits
      logic [`PACK_LEN_W-1:0]   len;
      // closes the current word with zero padding
      logic                     last;
   } pack_field_t;

   // one packed output word
   typedef logic [`PACK_WORD_W-1:0] pack_word_t;

   // controller states
   typedef enum logic [1:0] {
      // no field held, may fetch
      EMPTY = 2'd0,
      // field held, waiting for room in the bit fifo
      HELD  = 2'd1,
      // last field pushed, pad to the word boundary
      PAD   = 2'd2
   } pack_state_t;

endpackage

//--- verilog/pack_macros.svh
`ifndef PACK_MACROS_SVH
`define PACK_MACROS_SVH

// widest field the source can hand over
`define PACK_FIELD_W 8

// length field, holds 1 to 8
`define PACK_LEN_W 4

// packed output word
`define PACK_WORD_W 32

// bit fifo capacity, twice the wider of field and word
`define PACK_BFIFO_W 64

// level and room counters, must reach PACK_BFIFO_W
`define PACK_LEVEL_W 7

// entries in the input and output queues
`define PACK_QUEUE_DEPTH 4

`endif
